/* include/spi_dac_defs.svh */
// ------------------------------------------------
// frame timing and DAC command codes of the SPI DAC
// controller, included by the RTL and the testbench
// ------------------------------------------------
`ifndef SPI_DAC_DEFS_SVH
`define SPI_DAC_DEFS_SVH

// frame timer
`define SPI_FRAME_LEN 1024
`define SPI_TIMER_BITS 10

// one DAC command is cmd, addr and data
`define DAC_WORD_BITS 24

// chip-select window points in frame counts
`define DAC_CS_A_END 10'd49
`define DAC_CS_B_START 10'd51
`define DAC_CS_B_END 10'd99

// DAC command and channel address codes
`define DAC_CMD_WRITE_UPDATE 4'b0011
`define DAC_ADDR_A 4'b0000
`define DAC_ADDR_B 4'b0001

`endif

/* hdl/spi_dac_pkg.sv */
// ------------------------------------------------
// shared types of the SPI DAC controller: samples,
// DAC command words and the bus lines
// ------------------------------------------------

package spi_dac_pkg;

  timeunit 1ns;
  timeprecision 1ps;

  // host stereo pair, two's complement
  typedef struct packed {
    logic [15:0] left;
    logic [15:0] right;
  } stereo_sample_t;

  // DAC command word as sent, MSB first
  typedef struct packed {
    logic [3:0] cmd;
    logic [3:0] addr;
    logic [15:0] data;
  } dac_cmd_fields_t;

  // one command word, built by fields, shifted raw
  typedef union packed {
    logic [23:0] raw;
    dac_cmd_fields_t fields;
  } dac_word_u;

  // lines put on the shared SPI bus for the DAC
  typedef struct packed {
    logic sck;
    logic mosi;
    logic dac_cs_n;
  } spi_bus_t;

endpackage

/* hdl/spi_frame_timer.sv */
// ------------------------------------------------
// frame counter for the SPI DAC commands; parks at
// count 0 while disabled, gives sck and frame start
// ------------------------------------------------
`timescale 1ns/1ps

`include "spi_dac_defs.svh"

module spi_frame_timer
  import spi_dac_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       spi_en,
  output logic [`SPI_TIMER_BITS-1:0] count,
  output logic                       sck,
  output logic                       frame_start
);

  // ------------------------------------------------
  // frame count
  // ------------------------------------------------

  logic hold;
  logic last;

  // only stop between frames, never mid-frame
  assign hold = !spi_en && (count == '0);
  assign last = (count == `SPI_FRAME_LEN - 1);

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (hold) begin
      count <= count;
    end else if (last) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // ------------------------------------------------
  // derived bus clock and frame pulse
  // ------------------------------------------------

  // half the system clock
  assign sck = count[0];

  // one cycle per frame, at count 1
  assign frame_start = (count == `SPI_TIMER_BITS'(1));

endmodule

/* hdl/sample_holder.sv */
// ------------------------------------------------
// keeps the newest host stereo pair and flags frames
// that start without a fresh pair
// ------------------------------------------------
`timescale 1ns/1ps

module sample_holder
  import spi_dac_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  logic           sample_wr,
  input  stereo_sample_t sample_in,
  input  logic           frame_start,
  output stereo_sample_t cur_sample,
  output logic           sample_underrun
);

  logic fresh;

  // newest pair, overwritten by every write
  always_ff @(posedge clk) begin
    if (reset) begin
      cur_sample <= '0;
    end else if (sample_wr) begin
      cur_sample <= sample_in;
    end
  end

  // ------------------------------------------------
  // fresh flag and underrun pulse
  // ------------------------------------------------

  // a write together with frame_start still counts
  // for this frame, the flag is then cleared anyway
  always_ff @(posedge clk) begin
    if (reset) begin
      fresh <= 1'b0;
      sample_underrun <= 1'b0;
    end else begin
      sample_underrun <= frame_start && !fresh && !sample_wr;
      if (frame_start) begin
        fresh <= 1'b0;
      end else if (sample_wr) begin
        fresh <= 1'b1;
      end
    end
  end

endmodule

/* hdl/dac_frame_shifter.sv */
// ------------------------------------------------
// builds the two DAC command words of a frame and
// shifts them out in their chip-select windows
// ------------------------------------------------
`timescale 1ns/1ps

`include "spi_dac_defs.svh"

module dac_frame_shifter
  import spi_dac_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`SPI_TIMER_BITS-1:0] count,
  input  logic                       sck,
  input  logic                       frame_start,
  input  stereo_sample_t             cur_sample,
  output spi_bus_t                   bus
);

  // word 1 goes out first (channel A), word 0 second
  dac_word_u [1:0] sr;
  logic [2*`DAC_WORD_BITS-1:0] sr_bits;
  logic cs_n;
  logic shift;

  assign sr_bits = sr;

  // ------------------------------------------------
  // chip-select windows
  // ------------------------------------------------

  // window A: counts 2..49, window B: counts 52..99
  always_ff @(posedge clk) begin
    if (reset) begin
      cs_n <= 1'b1;
    end else if (frame_start) begin
      cs_n <= 1'b0;
    end else if (count == `DAC_CS_A_END) begin
      cs_n <= 1'b1;
    end else if (count == `DAC_CS_B_START) begin
      cs_n <= 1'b0;
    end else if (count == `DAC_CS_B_END) begin
      cs_n <= 1'b1;
    end
  end

  // move on after the DAC has seen the rising sck
  assign shift = sck && !cs_n;

  // ------------------------------------------------
  // command word load and shift
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (frame_start) begin
      sr[1].fields.cmd  <= `DAC_CMD_WRITE_UPDATE;
      sr[1].fields.addr <= `DAC_ADDR_A;
      // offset binary for the DAC
      sr[1].fields.data <= {~cur_sample.left[15], cur_sample.left[14:0]};
      sr[0].fields.cmd  <= `DAC_CMD_WRITE_UPDATE;
      sr[0].fields.addr <= `DAC_ADDR_B;
      sr[0].fields.data <= {~cur_sample.right[15], cur_sample.right[14:0]};
    end else if (shift) begin
      sr <= {sr_bits[2*`DAC_WORD_BITS-2:0], 1'b0};
    end
  end

  // ------------------------------------------------
  // bus lines
  // ------------------------------------------------

  assign bus.sck = sck;
  assign bus.mosi = sr[1].raw[`DAC_WORD_BITS-1];
  assign bus.dac_cs_n = cs_n;

endmodule

/* hdl/spi_dac_ctrl.sv */
// ------------------------------------------------
// top level of the SPI DAC controller; connects the
// timer, sample holder and shifter, idles the others
// ------------------------------------------------
`timescale 1ns/1ps

`include "spi_dac_defs.svh"

module spi_dac_ctrl
  import spi_dac_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  logic           spi_en,
  input  logic           sample_wr,
  input  stereo_sample_t sample_in,
  output logic           sample_underrun,
  output logic           spi_sck,
  output logic           spi_mosi,
  output logic           dac_cs_n,
  output logic           dac_clr_n,
  output logic           amp_cs_n,
  output logic           amp_shdn,
  output logic           ad_conv
);

  logic [`SPI_TIMER_BITS-1:0] count;
  logic sck;
  logic frame_start;
  stereo_sample_t cur_sample;
  spi_bus_t bus;

  // ------------------------------------------------
  // frame timing
  // ------------------------------------------------

  spi_frame_timer i_spi_frame_timer (
    .clk         (clk),
    .reset       (reset),
    .spi_en      (spi_en),
    .count       (count),
    .sck         (sck),
    .frame_start (frame_start)
  );

  // ------------------------------------------------
  // host samples and DAC commands
  // ------------------------------------------------

  sample_holder i_sample_holder (
    .clk             (clk),
    .reset           (reset),
    .sample_wr       (sample_wr),
    .sample_in       (sample_in),
    .frame_start     (frame_start),
    .cur_sample      (cur_sample),
    .sample_underrun (sample_underrun)
  );

  dac_frame_shifter i_dac_frame_shifter (
    .clk         (clk),
    .reset       (reset),
    .count       (count),
    .sck         (sck),
    .frame_start (frame_start),
    .cur_sample  (cur_sample),
    .bus         (bus)
  );

  assign spi_sck = bus.sck;
  assign spi_mosi = bus.mosi;
  assign dac_cs_n = bus.dac_cs_n;

  // ------------------------------------------------
  // other devices on the shared bus
  // ------------------------------------------------

  // DAC clear only during reset
  assign dac_clr_n = ~reset;
  // amplifier never selected, shut down in reset
  assign amp_cs_n = 1'b1;
  assign amp_shdn = reset;
  // no ADC conversions
  assign ad_conv = 1'b0;

endmodule

/* tb/tb_spi_dac.sv */
// ------------------------------------------------
// random-stimulus testbench of the SPI DAC controller
// with a serial receiver model on the DAC bus lines
// ------------------------------------------------
`timescale 1ns/1ps

`include "spi_dac_defs.svh"

module tb_spi_dac
  import spi_dac_pkg::*;
();

  localparam int num_frames = 24;
  localparam int frame_timeout = 2200;

  logic clk;
  logic reset;
  logic spi_en;
  logic sample_wr;
  stereo_sample_t sample_in;
  logic sample_underrun;
  logic spi_sck;
  logic spi_mosi;
  logic dac_cs_n;
  logic dac_clr_n;
  logic amp_cs_n;
  logic amp_shdn;
  logic ad_conv;

  integer seed = 32'h58ac;
  // set while spi_en is low and the timer is parked
  logic idle_check = 1'b0;

  // receiver and model state
  int cyc = 0;
  int bits = 0;
  int win_idx = 0;
  int frame_cyc = 0;
  int rise_ref = 0;
  int words_checked = 0;
  logic prev_cs_n = 1'b1;
  logic prev_sck = 1'b0;
  logic prev_idle = 1'b0;
  logic prev_reset = 1'b1;
  logic have_frame = 1'b0;
  logic en_gap = 1'b0;
  logic expect_first = 1'b0;
  logic wrote_since = 1'b0;
  logic [`DAC_WORD_BITS-1:0] word = '0;
  stereo_sample_t latest_pair = '0;
  stereo_sample_t frame_pair = '0;

  spi_dac_ctrl i_spi_dac_ctrl (
    .clk             (clk),
    .reset           (reset),
    .spi_en          (spi_en),
    .sample_wr       (sample_wr),
    .sample_in       (sample_in),
    .sample_underrun (sample_underrun),
    .spi_sck         (spi_sck),
    .spi_mosi        (spi_mosi),
    .dac_cs_n        (dac_cs_n),
    .dac_clr_n       (dac_clr_n),
    .amp_cs_n        (amp_cs_n),
    .amp_shdn        (amp_shdn),
    .ad_conv         (ad_conv)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------
  // error reporting and helpers
  // ------------------------------------------------

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    abort_run($sformatf("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual));
  endtask

  function automatic int pick_below(input int n);
    pick_below = int'($unsigned($random(seed)) % n);
  endfunction

  // command, channel address, sample in offset binary
  function automatic logic [`DAC_WORD_BITS-1:0] expected_word(input int ch,
                                                              input stereo_sample_t s);
    logic [15:0] v;
    logic [3:0] addr;
    if (ch == 0) begin
      v = s.left;
      addr = `DAC_ADDR_A;
    end else begin
      v = s.right;
      addr = `DAC_ADDR_B;
    end
    expected_word = {`DAC_CMD_WRITE_UPDATE, addr, v + 16'h8000};
  endfunction

  // ------------------------------------------------
  // bus monitor, receiver and checks
  // ------------------------------------------------

  always @(posedge clk) begin
    logic cs_fall;
    logic cs_rise;
    logic sck_rise;
    logic [`DAC_WORD_BITS-1:0] exp_word;
    string wname;
    cyc = cyc + 1;
    cs_fall = prev_cs_n && !dac_cs_n;
    cs_rise = !prev_cs_n && dac_cs_n;
    sck_rise = spi_sck && !prev_sck;
    assert (amp_cs_n == 1'b1) else report_mismatch("amp_cs_n", 32'd1, 32'(amp_cs_n));
    assert (ad_conv == 1'b0) else report_mismatch("ad_conv", 32'd0, 32'(ad_conv));
    if (reset) begin
      // first edge has not applied reset yet
      if (cyc > 1) begin
        assert (dac_cs_n == 1'b1) else report_mismatch("reset_cs_n", 32'd1, 32'(dac_cs_n));
        assert (spi_sck == 1'b0) else report_mismatch("reset_sck", 32'd0, 32'(spi_sck));
        assert (dac_clr_n == 1'b0) else report_mismatch("reset_clr_n", 32'd0, 32'(dac_clr_n));
        assert (amp_shdn == 1'b1) else report_mismatch("reset_amp_shdn", 32'd1, 32'(amp_shdn));
      end
    end else begin
      assert (dac_clr_n == 1'b1) else report_mismatch("run_clr_n", 32'd1, 32'(dac_clr_n));
      assert (amp_shdn == 1'b0) else report_mismatch("run_amp_shdn", 32'd0, 32'(amp_shdn));
      // last cycle at count 0 before the timer runs
      if (prev_reset || (prev_idle && !idle_check)) begin
        rise_ref = cyc;
        expect_first = 1'b1;
      end
      if (idle_check) begin
        assert (spi_sck == prev_sck && dac_cs_n == 1'b1)
          else abort_run("bus activity on spi_sck or dac_cs_n while disabled between frames");
        en_gap = 1'b1;
      end
      if (cs_fall && win_idx == 0) begin
        // frame start, underrun pulse lines up with the first window
        assert (sample_underrun == !wrote_since)
          else report_mismatch("underrun", 32'(!wrote_since), 32'(sample_underrun));
        if (have_frame && !en_gap) begin
          assert (cyc - frame_cyc == `SPI_FRAME_LEN)
            else report_mismatch("frame_spacing", `SPI_FRAME_LEN, cyc - frame_cyc);
        end
        frame_cyc = cyc;
        have_frame = 1'b1;
        en_gap = 1'b0;
        wrote_since = 1'b0;
        frame_pair = latest_pair;
        bits = 0;
        word = '0;
      end else begin
        assert (sample_underrun == 1'b0)
          else report_mismatch("stray_underrun", 32'd0, 32'(sample_underrun));
        if (cs_fall) begin
          assert (cyc - frame_cyc == int'(`DAC_CS_B_START) - 1)
            else report_mismatch("window_b_start", int'(`DAC_CS_B_START) - 1, cyc - frame_cyc);
          bits = 0;
          word = '0;
        end
      end
      // DAC side capture on rising sck
      if (sck_rise && !dac_cs_n) begin
        word = {word[`DAC_WORD_BITS-2:0], spi_mosi};
        bits = bits + 1;
        if (expect_first) begin
          assert (cyc - rise_ref == 3)
            else report_mismatch("first_sck_delay", 32'd3, cyc - rise_ref);
          expect_first = 1'b0;
        end
      end
      if (cs_rise) begin
        exp_word = expected_word(win_idx, frame_pair);
        if (win_idx == 0) begin
          wname = "word_a";
        end else begin
          wname = "word_b";
        end
        assert (bits == `DAC_WORD_BITS)
          else report_mismatch("window_bits", `DAC_WORD_BITS, bits);
        assert (word == exp_word) else report_mismatch(wname, 32'(exp_word), 32'(word));
        words_checked = words_checked + 1;
        win_idx = 1 - win_idx;
      end
      // writes seen here belong to the next frame
      if (sample_wr) begin
        latest_pair = sample_in;
        wrote_since = 1'b1;
      end
    end
    prev_cs_n = dac_cs_n;
    prev_sck = spi_sck;
    prev_idle = idle_check;
    prev_reset = reset;
  end

  // ------------------------------------------------
  // stimulus
  // ------------------------------------------------

  task automatic wait_frame_start();
    int n;
    logic last_cs;
    logic found;
    n = 0;
    found = 1'b0;
    last_cs = dac_cs_n;
    while (!found && n < frame_timeout) begin
      @(posedge clk);
      found = last_cs && !dac_cs_n;
      last_cs = dac_cs_n;
      n = n + 1;
    end
    assert (found) else abort_run("timeout waiting for a frame to start on dac_cs_n");
  endtask

  // one frame of host writes, maybe ending with the enable dropped
  task automatic run_frame();
    int t;
    int last_t;
    int wr_off;
    int wr2_off;
    int drop_off;
    logic do_write;
    logic do_wr2;
    logic do_drop;
    logic [31:0] rnd;
    do_write = (pick_below(5) != 0);
    do_wr2 = (pick_below(4) == 0);
    do_drop = (pick_below(5) == 0);
    wr_off = 1 + pick_below(900);
    wr2_off = wr_off + 1 + pick_below(100);
    drop_off = 1 + pick_below(1000);
    last_t = do_drop ? 1030 : 1010;
    for (t = 1; t <= last_t; t++) begin
      @(posedge clk);
      if (do_write && (t == wr_off || (do_wr2 && t == wr2_off))) begin
        rnd = $random(seed);
        sample_wr <= 1'b1;
        sample_in <= rnd;
      end else begin
        sample_wr <= 1'b0;
      end
      if (do_drop && t == drop_off) begin
        spi_en <= 1'b0;
      end
    end
    if (do_drop) begin
      // timer sits at count 0 by now
      idle_check <= 1'b1;
      repeat (4 + pick_below(40)) @(posedge clk);
      spi_en <= 1'b1;
      idle_check <= 1'b0;
    end
  endtask

  initial begin
    int f;
    reset = 1'b1;
    spi_en = 1'b1;
    sample_wr = 1'b0;
    sample_in = '0;
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    for (f = 0; f < num_frames; f++) begin
      wait_frame_start();
      run_frame();
    end
    if (words_checked == 2 * num_frames) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      report_mismatch("word_count", 2 * num_frames, words_checked);
    end
  end

endmodule

/* spi_dac.f */
+incdir+include
hdl/spi_dac_pkg.sv
hdl/spi_frame_timer.sv
hdl/sample_holder.sv
hdl/dac_frame_shifter.sv
hdl/spi_dac_ctrl.sv
tb/tb_spi_dac.sv

/* run_sim.sh */
#!/bin/sh
# build the SPI DAC testbench with Verilator and run it into sim.log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_spi_dac \
  -f spi_dac.f \
  -o Vtb_spi_dac

# a failing run exits non-zero, the log search below gives the verdict
./obj_dir/Vtb_spi_dac > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
